/* common/wormPkg.sv */
`default_nettype none

package wormPkg;

   // router size
   localparam int numPorts = 4;                  // inputs and outputs
   localparam int portW    = 2;                  // bits of a port number
   localparam int flitW    = 8;                  // bits of a flit

   // flit field widths, derived from the flit width
   localparam int kindW    = 2;                  // flit type field
   localparam int tagW     = flitW - kindW - portW; // header payload
   localparam int payloadW = flitW - kindW;      // body/tail payload

   // flit type codes, bits 7:6 of every flit
   localparam logic [kindW-1:0] flitEmpty = 2'b00; // no data
   localparam logic [kindW-1:0] flitHead  = 2'b01; // opens a packet
   localparam logic [kindW-1:0] flitBody  = 2'b10; // payload only
   localparam logic [kindW-1:0] flitTail  = 2'b11; // closes a packet

   // input decoder states
   localparam logic [1:0] stIdle = 2'b00;        // no connection
   localparam logic [1:0] stWait = 2'b01;        // header held, waiting for grant
   localparam logic [1:0] stOpen = 2'b10;        // connection open

   // one flit word, read as header or as data flit
   typedef union packed
   {
      struct packed
      {
         logic [kindW-1:0] kind;                 // always flitHead here
         logic [portW-1:0] dest;                 // destination output
         logic [tagW-1:0]  tag;                  // header payload
      } head;
      struct packed
      {
         logic [kindW-1:0]    kind;              // flitBody or flitTail
         logic [payloadW-1:0] payload;           // data bits
      } data;
   } flitT;

   // one bit per port: request, grant and take vectors
   typedef logic [numPorts-1:0] portVecT;

endpackage

`default_nettype wire

/* hdl/flitDecoder.sv */
`default_nettype none

module flitDecoder
   import wormPkg::*;
(
   input  wire          clk,
   input  wire          arstN,
   input  wire          inValid,                // input side handshake
   input  wire flitT    inFlit,
   output logic         inRdy,
   output portVecT      rqst,                   // one-hot on destination while open
   input  wire portVecT grant,                  // bit j from output j
   input  wire portVecT take,                   // bit j from output j
   output flitT         flit,                   // the one-flit register
   output logic         flitValid
);

   logic [1:0]       state;                     // idle, wait, open
   logic [portW-1:0] destReg;                   // latched header destination
   logic             taken;                     // some output stores our flit now
   logic             holdsTail;                 // register has the packet end
   logic             tailGone;                  // tail leaves at this edge
   logic             accept;                    // input transfer at this edge
   logic             isHead;
   logic             isData;
   logic             loadFlit;                  // accepted flit goes into the register

   assign taken     = |take;
   assign holdsTail = flitValid && (flit.data.kind == flitTail);
   assign tailGone  = taken && holdsTail;

   // room when empty or draining, but never past a tail
   assign inRdy  = !flitValid || (taken && !holdsTail);
   assign accept = inValid && inRdy;

   assign isHead = (inFlit.head.kind == flitHead);
   assign isData = (inFlit.data.kind == flitBody) || (inFlit.data.kind == flitTail);

   // idle keeps headers only, open keeps body and tail, the rest drops
   assign loadFlit = accept && ((state == stIdle) ? isHead : isData);

   always_comb
   begin
      rqst = '0;
      if (state != stIdle)
         rqst[destReg] = 1'b1;                  // held until the tail is taken
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state <= stIdle;
      end
      else
      begin
         case (state)
            stIdle:
            begin
               if (loadFlit)
                  state <= stWait;               // header latched, request goes up
            end
            stWait:
            begin
               if (|(grant & rqst))
                  state <= stOpen;               // header may already be taken here
            end
            stOpen:
            begin
               if (tailGone)
                  state <= stIdle;               // drops rqst, grant follows a cycle later
            end
            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

   // register occupancy
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         flitValid <= 1'b0;
      end
      else if (tailGone)
      begin
         flitValid <= 1'b0;                      // nothing loads behind a tail
      end
      else if (loadFlit)
      begin
         flitValid <= 1'b1;                      // refill, same edge as a take too
      end
      else if (taken)
      begin
         flitValid <= 1'b0;
      end
   end

   // payload
   always_ff @(posedge clk)
   begin
      if (loadFlit)
         flit <= inFlit;
      if (loadFlit && (state == stIdle))
         destReg <= inFlit.head.dest;            // route for the whole packet
   end

   // at most one output is requested
   rqstOneHot: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0(rqst))
      else $error("decoder request is not one-hot");

   // the register never offers an empty flit to an output
   noEmptyFlit: assert property (@(posedge clk) disable iff (!arstN)
      flitValid |-> (flit.data.kind != flitEmpty))
      else $error("decoder offers an empty flit");

endmodule

`default_nettype wire

/* hdl/outputPort.sv */
`default_nettype none

module outputPort
   import wormPkg::*;
(
   input  wire          clk,
   input  wire          arstN,
   input  wire portVecT rqst,                   // bit i from decoder i
   input  wire flitT    flitIn [numPorts],      // every decoder register
   input  wire portVecT flitValidIn,
   output portVecT      grant,                  // held for a whole packet
   output portVecT      take,                   // store decoder i's flit now
   output logic         outValid,               // output side handshake
   output flitT         outFlit,
   input  wire          outRdy
);

   logic [portW-1:0] lastWinner;                // also the granted index
   logic [portW-1:0] nextWinner;                // round-robin choice
   logic [portW-1:0] cand;
   logic             anyRqst;
   logic             outFree;                   // register empty or draining
   flitT             selFlit;                   // crossbar mux output

   // search starts after the last winner, wraps around to it
   always_comb
   begin
      nextWinner = lastWinner;
      anyRqst    = 1'b0;
      cand       = lastWinner;
      for (int k = 1; k <= numPorts; k++)
      begin
         cand = lastWinner + portW'(k);
         if (!anyRqst && rqst[cand])
         begin
            nextWinner = cand;
            anyRqst    = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         grant      <= '0;
         lastWinner <= '0;
      end
      else if (grant == '0)
      begin
         if (anyRqst)
         begin
            grant[nextWinner] <= 1'b1;          // grant is zero in this branch
            lastWinner        <= nextWinner;
         end
      end
      else if ((grant & rqst) == '0)
      begin
         grant <= '0;                            // tail has left the decoder
      end
   end

   assign outFree = !outValid || outRdy;
   assign take    = grant & flitValidIn & {numPorts{outFree}};
   assign selFlit = flitIn[lastWinner];          // valid whenever grant is set

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         outValid <= 1'b0;
      end
      else if (|take)
      begin
         outValid <= 1'b1;
      end
      else if (outRdy)
      begin
         outValid <= 1'b0;                       // drained, nothing new
      end
   end

   always_ff @(posedge clk)
   begin
      if (|take)
         outFlit <= selFlit;
   end

   // one winner at a time
   grantOneHot: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0(grant))
      else $error("output grant is not one-hot");

   // a new grant only goes to a decoder that was requesting
   grantFromRqst: assert property (@(posedge clk) disable iff (!arstN)
      $rose(|grant) |-> ((grant & ~$past(rqst)) == '0))
      else $error("output granted a port without a request");

   // stalled output holds its flit
   holdStable: assert property (@(posedge clk) disable iff (!arstN)
      (outValid && !outRdy) |=> (outValid && $stable(outFlit)))
      else $error("output flit changed under back-pressure");

endmodule

`default_nettype wire

/* hdl/wormRouter.sv */
`default_nettype none

module wormRouter
   import wormPkg::*;
(
   input  wire          clk,
   input  wire          arstN,
   input  wire portVecT inValid,
   input  wire flitT    inFlit [numPorts],
   output wire portVecT inRdy,
   output wire portVecT outValid,
   output wire flitT    outFlit [numPorts],
   input  wire portVecT outRdy
);

   wire portVecT decRqst   [numPorts];           // decoder i, bit j for output j
   wire portVecT portRqst  [numPorts];           // output j, bit i from decoder i
   wire portVecT portGrant [numPorts];           // output j, bit i to decoder i
   wire portVecT decGrant  [numPorts];           // decoder i, bit j from output j
   wire portVecT portTake  [numPorts];
   wire portVecT decTake   [numPorts];
   wire flitT    decFlit   [numPorts];           // decoder registers to every output
   wire portVecT decFlitValid;

   // matrix transpose between the decoder and output sides
   for (genvar i = 0; i < numPorts; i++)
   begin : gRow
      for (genvar j = 0; j < numPorts; j++)
      begin : gCol
         assign portRqst[j][i] = decRqst[i][j];
         assign decGrant[i][j] = portGrant[j][i];
         assign decTake[i][j]  = portTake[j][i];
      end
   end

   for (genvar i = 0; i < numPorts; i++)
   begin : gIn
      flitDecoder i_flitDecoder
      (
         .clk       (clk),
         .arstN     (arstN),
         .inValid   (inValid[i]),
         .inFlit    (inFlit[i]),
         .inRdy     (inRdy[i]),
         .rqst      (decRqst[i]),
         .grant     (decGrant[i]),
         .take      (decTake[i]),
         .flit      (decFlit[i]),
         .flitValid (decFlitValid[i])
      );
   end

   for (genvar j = 0; j < numPorts; j++)
   begin : gOut
      outputPort i_outputPort
      (
         .clk         (clk),
         .arstN       (arstN),
         .rqst        (portRqst[j]),
         .flitIn      (decFlit),
         .flitValidIn (decFlitValid),
         .grant       (portGrant[j]),
         .take        (portTake[j]),
         .outValid    (outValid[j]),
         .outFlit     (outFlit[j]),
         .outRdy      (outRdy[j])
      );
   end

endmodule

`default_nettype wire

/* tests/clkGen.sv */
`default_nettype none

module clkGen
(
   output logic clk,
   output logic arstN
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk   = 1'b0;
      arstN = 1'b0;                              // held over three rising edges
      #120 arstN = 1'b1;                         // released on a falling edge
   end

   always #20 clk = ~clk;                        // 40 ns period

endmodule

`default_nettype wire

/* tests/wormRouterTb.sv */
`default_nettype none

module wormRouterTb
   import wormPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   wire logic clk, arstN;
   portVecT inValid, outRdy;
   wire portVecT inRdy, outValid;
   flitT inFlit [numPorts];
   wire flitT outFlit [numPorts];

   flitT expQ [numPorts][numPorts][$];           // [dest][src], flits still to leave
   flitT pendFlit [numPorts][$];                 // per input, flits not yet accepted
   int   pendDest [numPorts][$];                 // -1 marks a stray flit
   int   pktsMade [numPorts];
   int   inFlight [numPorts];                    // packets of a source inside the router
   int   waitCnt [numPorts];                     // cycles since that source's last tail
   logic [portW-1:0] curSrc [numPorts];          // source of the open packet per output
   portVecT pktOpen, fireV, matchOk, wormOk;
   logic [31:0] lfsr;

   clkGen i_clkGen (.clk(clk), .arstN(arstN));

   wormRouter i_wormRouter (.clk(clk), .arstN(arstN), .inValid(inValid), .inFlit(inFlit),
      .inRdy(inRdy), .outValid(outValid), .outFlit(outFlit), .outRdy(outRdy));

   task automatic abortRun();
      $display("Simulation failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic valueError(string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      abortRun();
   endtask

   task automatic plainFail(string msg);
      $display("%s", msg);
      abortRun();
   endtask

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic int drawBits(int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   function automatic logic [portW-1:0] srcOf(flitT f);
      if (f.head.kind == flitHead)
         return f.head.tag[tagW-1 -: portW];    // tag is {src, seq}
      return f.data.payload[payloadW-1 -: portW]; // payload is {src, index}
   endfunction

   // header, 1 to 4 bodies, tail; packets 10 on all go to output 2
   task automatic makePacket(int i);
      flitT f;
      int   dest, nBody;
      if (drawBits(3) == 0)
      begin
         f.data.kind    = drawBits(1) ? flitTail : flitBody;
         f.data.payload = {portW'(i), 4'hf};     // index 15 is never a real flit
         pendFlit[i].push_back(f);
         pendDest[i].push_back(-1);
      end
      dest  = (pktsMade[i] < 10) ? drawBits(2) : 2;
      nBody = drawBits(2) + 1;
      f.head.kind = flitHead;
      f.head.dest = portW'(dest);
      f.head.tag  = {portW'(i), 2'(pktsMade[i])};
      pendFlit[i].push_back(f);
      pendDest[i].push_back(dest);
      for (int k = 1; k <= nBody + 1; k++)
      begin
         f.data.kind    = (k > nBody) ? flitTail : flitBody;
         f.data.payload = {portW'(i), 4'(k)};
         pendFlit[i].push_back(f);
         pendDest[i].push_back(dest);
      end
      pktsMade[i]++;
   endtask

   // output transfers of this edge, checked against queues at the falling edge before
   task automatic trackOutputs();
      logic [portW-1:0] s;
      for (int j = 0; j < numPorts; j++)
      begin
         if (outValid[j] && outRdy[j])
         begin
            s = srcOf(outFlit[j]);
            if (expQ[j][s].size() > 0)
               void'(expQ[j][s].pop_front());
            if (outFlit[j].head.kind == flitHead)
            begin
               pktOpen[j] = 1'b1;
               curSrc[j]  = s;
            end
            else if (outFlit[j].data.kind == flitTail)
            begin
               pktOpen[j] = 1'b0;
               inFlight[s]--;
               waitCnt[s] = 0;
            end
         end
      end
      for (int i = 0; i < numPorts; i++)
         if (inFlight[i] > 0)
            waitCnt[i]++;
   endtask

   task automatic driveInputs();
      flitT f;
      int   d;
      for (int i = 0; i < numPorts; i++)
      begin
         if (inValid[i] && inRdy[i])
         begin
            d = pendDest[i].pop_front();
            f = pendFlit[i].pop_front();
            if (d >= 0)
               expQ[d][i].push_back(f);          // strays are expected nowhere
            if (d >= 0 && f.head.kind == flitHead)
               inFlight[i]++;
         end
         if (!inValid[i] || inRdy[i])
         begin
            if (pendFlit[i].size() == 0 && pktsMade[i] < 16)
               makePacket(i);
            inValid[i] <= (pendFlit[i].size() > 0) && (drawBits(2) != 0); // random gaps
            if (pendFlit[i].size() > 0)
               inFlit[i] <= pendFlit[i][0];
         end
      end
      for (int j = 0; j < numPorts; j++)
         outRdy[j] <= (drawBits(2) != 0);        // low about one cycle in four
   endtask

   // expected values for the next rising edge
   always @(negedge clk)
   begin
      logic [portW-1:0] s;
      for (int j = 0; j < numPorts; j++)
      begin
         s          = srcOf(outFlit[j]);
         fireV[j]   = outValid[j] && outRdy[j];
         matchOk[j] = (expQ[j][s].size() > 0) && (expQ[j][s][0] == outFlit[j]);
         wormOk[j]  = (outFlit[j].head.kind == flitHead) ? !pktOpen[j] :
                      (pktOpen[j] && (s == curSrc[j]));
      end
   end

   for (genvar j = 0; j < numPorts; j++)
   begin : gCheck
      routeOrder: assert property (@(posedge clk) disable iff (!arstN) fireV[j] |-> matchOk[j])
         else valueError($sformatf("output %0d sent unexpected flit %h", j,
                                   $sampled(outFlit[j])));
      wormhole: assert property (@(posedge clk) disable iff (!arstN) fireV[j] |-> wormOk[j])
         else valueError($sformatf("output %0d interleaved packets", j));
      holdFlit: assert property (@(posedge clk) disable iff (!arstN)
         (outValid[j] && !outRdy[j]) |=> (outValid[j] && $stable(outFlit[j])))
         else valueError($sformatf("output %0d changed under back-pressure", j));
      noStarve: assert property (@(posedge clk) disable iff (!arstN) waitCnt[j] < 400)
         else plainFail($sformatf("a packet from input %0d was not delivered in time", j));
   end

   initial
   begin
      int cyc, idleCnt;
      lfsr    = 32'hba09_9ccb;
      inValid = '0;
      outRdy  = '1;
      pktOpen = '0;
      fireV   = '0;
      for (int i = 0; i < numPorts; i++)
      begin
         inFlit[i]   = '0;
         pktsMade[i] = 0;
         inFlight[i] = 0;
         waitCnt[i]  = 0;
         curSrc[i]   = '0;
      end
      cyc = 0;
      while (arstN !== 1'b1 && cyc < 20)
      begin
         @(posedge clk);
         cyc++;
      end
      if (arstN !== 1'b1)
         plainFail("reset was never released");
      resetIdle: assert (outValid == '0 && inRdy == '1)
         else valueError("outputs not idle in the first cycle after reset");
      cyc     = 0;
      idleCnt = 0;
      while (idleCnt < 8 && cyc < 20000)
      begin
         trackOutputs();
         driveInputs();
         if (inValid == '0 && outValid == '0 && inRdy == '1 && pktsMade.sum() == 64 &&
             pendFlit[0].size() + pendFlit[1].size() + pendFlit[2].size() +
             pendFlit[3].size() == 0)
            idleCnt++;                           // all sent and the router is quiet
         else
            idleCnt = 0;
         @(posedge clk);
         cyc++;
      end
      if (idleCnt < 8)
         plainFail("the router did not drain before the cycle limit");
      for (int j = 0; j < numPorts; j++)
         for (int s = 0; s < numPorts; s++)
            drained: assert (expQ[j][s].size() == 0)
               else valueError($sformatf("output %0d lost flits from input %0d", j, s));
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* wormRouter.f */
common/wormPkg.sv
hdl/flitDecoder.sv
hdl/outputPort.sv
hdl/wormRouter.sv
tests/clkGen.sv
tests/wormRouterTb.sv

/* Bender.yml */
package:
  name: wormRouter

sources:
  - common/wormPkg.sv
  - hdl/flitDecoder.sv
  - hdl/outputPort.sv
  - hdl/wormRouter.sv
  - target: test
    files:
      - tests/clkGen.sv
      - tests/wormRouterTb.sv
